// File: sprite_buf.f
+incdir+verilog
verilog/sprite_pkg.sv
verilog/obj_ram_arbiter.sv
verilog/obj_scanner.sv
verilog/line_buffer.sv
verilog/sprite_buf_top.sv
tests/sprite_buf_chk.sv
tests/sprite_buf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sprite line buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module sprite_buf_tb -f sprite_buf.f --Mdir obj_dir

# a fatal stop returns nonzero, the log search below decides the result
./obj_dir/Vsprite_buf_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

// File: tests/sprite_buf_tb.sv
/*
    sprite line buffer testbench
    directed tests; a model of the object RAM predicts each line
    from the zone rule (line - y mod 256 < 8) and the vflip row rule
*/
`timescale 1ns/100ps
`default_nettype none

`include "sprite_defs.svh"

module sprite_buf_tb;

    localparam int TIMEOUT_CYCLES = 4000;  // about four times the test traffic

    logic clk, reset, cpu_we, line_start, rd_en, rd_valid, overflow, scan_done;
    logic [5:0]          cpu_addr;
    logic [7:0]          cpu_data, line_v;
    logic [`SLOT_W-1:0]  rd_slot;
    logic [`ENTRY_W-1:0] rd_entry;
    logic [`SLOT_W:0]    slot_count;
    logic [31:0]         model [`OBJ_COUNT];  // object words with y in byte 0
    logic                done_flag;           // scan_done seen since line start
    int                  cycles = 0;

    sprite_buf_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles, a scan never finished", cycles);
            $display("tests failed");
            $fatal(1, "timeout");
        end else if (u_dut.u_chk.err_count != 0) begin
            $display("a checker assertion failed before %0t", $time);
            $display("tests failed");
            $fatal(1, "assertion");
        end
    end

    task automatic step();  // one edge then 1 ns for the inputs
        @(posedge clk);
        #1;
        if (scan_done) done_flag = 1'b1;
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "first mismatch");
        end
    endtask

    task automatic cpu_write(input logic [3:0] obj, input logic [1:0] bsel, input logic [7:0] d);
        cpu_we   = 1'b1;
        cpu_addr = {obj, bsel};
        cpu_data = d;
        model[obj][bsel*8 +: 8] = d;
        step();
        cpu_we   = 1'b0;
    endtask

    // random x, id and palette with the spare bits kept zero
    task automatic put_obj(input int idx, input logic [7:0] y, input logic bank,
                           input logic hflip, input logic vflip);
        logic [31:0] w;
        w = $urandom;
        w[7:0]   = y;
        w[23]    = bank;
        w[27]    = hflip;
        w[28]    = vflip;
        w[31:29] = 3'b000;
        for (int b = 0; b < 4; b++) cpu_write(4'(idx), 2'(b), w[b*8 +: 8]);
    endtask

    task automatic park_all(input logic [7:0] y);  // every object at one far line
        for (int i = 0; i < `OBJ_COUNT; i++) put_obj(i, y, 1'b0, 1'b0, 1'b0);
    endtask

    function automatic logic in_zone(input logic [31:0] w, input logic [7:0] tgt);
        logic [7:0] d;
        d = tgt - w[7:0];
        return d < `OBJ_H;
    endfunction

    // entry = {bank, id, pal, hflip, row, x}
    function automatic logic [`ENTRY_W-1:0] exp_entry(input logic [31:0] w, input logic [7:0] tgt);
        logic [7:0] d;
        logic [2:0] row;
        d   = tgt - w[7:0];
        row = w[28] ? 3'd7 - d[2:0] : d[2:0];  // vflip counts from the bottom
        return {w[23], w[22:16], w[26:24], w[27], row, w[15:8]};
    endfunction

    task automatic start_line(input logic [7:0] v);
        line_v     = v;
        line_start = 1'b1;
        step();
        line_start = 1'b0;
        done_flag  = 1'b0;
    endtask

    task automatic scan_line(input logic [7:0] v);
        start_line(v);
        while (!done_flag) step();
    endtask

    task automatic read_slot(input int slot, output logic [`ENTRY_W-1:0] e);
        rd_en   = 1'b1;
        rd_slot = `SLOT_W'(slot);
        step();
        rd_en   = 1'b0;
        check_eq(rd_valid, 1'b1, "rd_valid one cycle after rd_en");
        e = rd_entry;
    endtask

    // displayed half against the model for line tgt
    task automatic check_line(input logic [7:0] tgt);
        logic [`ENTRY_W-1:0] exp_q [$];
        logic [`ENTRY_W-1:0] got;
        int n;
        n = 0;
        for (int i = 0; i < `OBJ_COUNT; i++) begin
            if (in_zone(model[i], tgt)) begin
                n++;
                if (exp_q.size() < `LINE_SLOTS) exp_q.push_back(exp_entry(model[i], tgt));
            end
        end
        check_eq(slot_count, exp_q.size(), $sformatf("slot count, line %0d", tgt));
        check_eq(overflow, n > `LINE_SLOTS, $sformatf("overflow, line %0d", tgt));
        for (int s = 0; s < `LINE_SLOTS; s++) begin
            read_slot(s, got);
            check_eq(got, s < exp_q.size() ? exp_q[s] : '0,
                     $sformatf("slot %0d, line %0d", s, tgt));
        end
    endtask

    task automatic test_reset();
        logic [`ENTRY_W-1:0] got;
        check_eq(slot_count, 0, "slot count after reset");
        check_eq(overflow, 0, "overflow after reset");
        check_eq(scan_done, 0, "scan_done after reset");
        read_slot(0, got);
        check_eq(got, 0, "slot 0 after reset");
    endtask

    task automatic test_basic_zone();
        park_all(8'd200);
        put_obj(0, 8'd38, 1'b0, 1'b0, 1'b0);  // diff 3
        put_obj(1, 8'd60, 1'b1, 1'b0, 1'b0);  // below the line and out of zone
        put_obj(2, 8'd34, 1'b1, 1'b1, 1'b0);  // diff 7 is the last row
        put_obj(3, 8'd41, 1'b0, 1'b0, 1'b0);  // diff 0
        scan_line(8'd40);
        start_line(8'd41);
        check_eq(slot_count, 3, "three objects on line 41");
        check_line(8'd41);
    endtask

    task automatic test_vflip();
        logic [`ENTRY_W-1:0] got;
        park_all(8'd200);
        put_obj(4, 8'd50, 1'b1, 1'b1, 1'b1);  // diff 5 with vflip
        put_obj(6, 8'd52, 1'b0, 1'b0, 1'b1);
        put_obj(7, 8'd53, 1'b1, 1'b0, 1'b0);
        scan_line(8'd54);
        start_line(8'd55);
        read_slot(0, got);
        check_eq(got[10:8], 3'd7 - 3'd5, "vflip row");
        check_eq(got[11], model[4][27], "hflip passes");
        check_eq(got[14:12], model[4][26:24], "palette passes");
        check_eq(got[22], 1'b1, "bank passes");
        check_line(8'd55);
    endtask

    task automatic test_overflow();
        park_all(8'd150);
        for (int i = 0; i < 10; i++) begin  // y wraps below 0 around line 3
            put_obj(i, 8'd3 - 8'(i % 8), i[0], i[1], i[2]);
        end
        scan_line(8'd2);
        start_line(8'd3);
        check_eq(slot_count, 8, "full line");
        check_eq(overflow, 1'b1, "overflow on ten objects");
        check_line(8'd3);
        park_all(8'd150);
        scan_line(8'd10);
        start_line(8'd11);  // same half as the overflowed line
        check_line(8'd11);
    endtask

    task automatic test_cpu_collide();
        int k;
        park_all(8'd120);
        put_obj(2, 8'd70, 1'b0, 1'b1, 1'b0);
        put_obj(5, 8'd66, 1'b1, 1'b0, 1'b1);
        put_obj(9, 8'd64, 1'b0, 1'b0, 1'b0);
        start_line(8'd70);
        k = 0;
        while (!done_flag) begin
            if (k % 2 == 0) begin  // id byte of object 15 whose y stays out of zone
                cpu_we   = 1'b1;
                cpu_addr = {4'd15, 2'd2};
                cpu_data = 8'($urandom);
                model[15][23:16] = cpu_data;
            end
            step();
            cpu_we = 1'b0;
            k++;
        end
        start_line(8'd71);
        check_line(8'd71);
    endtask

    task automatic test_ping_pong();
        logic [`ENTRY_W-1:0] exp_slot [`LINE_SLOTS];
        logic [`ENTRY_W-1:0] got;
        int reads;
        park_all(8'd180);
        put_obj(0, 8'd121, 1'b0, 1'b0, 1'b0);  // in on 121 and 122
        put_obj(1, 8'd122, 1'b1, 1'b0, 1'b0);  // only 122
        put_obj(2, 8'd114, 1'b0, 1'b1, 1'b1);  // only 121
        scan_line(8'd120);
        start_line(8'd121);                    // 122 now scanning
        check_line(8'd121);
        for (int s = 0; s < `LINE_SLOTS; s++) exp_slot[s] = '0;
        exp_slot[0] = exp_entry(model[0], 8'd121);  // object order for line 121
        exp_slot[1] = exp_entry(model[2], 8'd121);
        reads = 0;
        while (!done_flag) begin
            read_slot(reads % `LINE_SLOTS, got);
            check_eq(got, exp_slot[reads % `LINE_SLOTS], "display half during scan");
            check_eq(slot_count, 2, "display count during scan");
            reads++;
        end
        check_eq(reads > 0, 1'b1, "reads overlapped the scan");
        check_line(8'd121);                    // still the old line
        start_line(8'd122);
        check_line(8'd122);
    endtask

    initial begin
        void'($urandom(32'hb8ea4e13));
        reset      = 1'b1;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_data   = '0;
        line_start = 1'b0;
        line_v     = '0;
        rd_en      = 1'b0;
        rd_slot    = '0;
        done_flag  = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        test_reset();
        test_basic_zone();
        test_vflip();
        test_overflow();
        test_cpu_collide();
        test_ping_pong();
        step();
        if (u_dut.u_chk.err_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: tests/sprite_buf_chk.sv
/*
    sprite buffer checker
    arbiter priority, readback latency and the line fill limit
*/
`timescale 1ns/100ps
`default_nettype none

`include "sprite_defs.svh"

module sprite_buf_chk (
    input wire             clk,
    input wire             reset,
    input wire             cpu_we,
    input wire             scan_gnt,
    input wire             rd_en,
    input wire             rd_valid,
    input wire [`SLOT_W:0] slot_count
);

    int err_count = 0;     // failed assertions so far

    // cpu owns the RAM in its write cycle
    a_gnt_excl: assert property (@(posedge clk) disable iff (reset) !(scan_gnt && cpu_we))
        else begin err_count++; $error("scan grant in a cpu write cycle"); end

    a_rd_lat: assert property (@(posedge clk) disable iff (reset) rd_valid == $past(rd_en))
        else begin err_count++; $error("rd_valid not one cycle after rd_en"); end

    a_cnt_max: assert property (@(posedge clk) disable iff (reset) slot_count <= `LINE_SLOTS)
        else begin err_count++; $error("slot count above line capacity"); end

endmodule

bind sprite_buf_top sprite_buf_chk u_chk (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .cpu_we     ( cpu_we     ),
    .scan_gnt   ( scan_gnt   ),
    .rd_en      ( rd_en      ),
    .rd_valid   ( rd_valid   ),
    .slot_count ( slot_count )
);

`default_nettype wire

// File: verilog/sprite_buf_top.sv
/*
    sprite line buffer subsystem
    object RAM and arbiter, line scanner and ping-pong buffer
*/
`timescale 1ns/100ps
`default_nettype none

`include "sprite_defs.svh"

module sprite_buf_top (
    input  wire                    clk,
    input  wire                    reset,
    // cpu port
    input  wire                    cpu_we,
    input  wire [5:0]              cpu_addr,
    input  wire [7:0]              cpu_data,
    // video timing
    input  wire                    line_start,
    input  wire [7:0]              line_v,
    // readback
    input  wire                    rd_en,
    input  wire [`SLOT_W-1:0]      rd_slot,
    output logic                   rd_valid,
    output logic [`ENTRY_W-1:0]    rd_entry,
    output logic [`SLOT_W:0]       slot_count,
    output logic                   overflow,
    output logic                   scan_done
);

    import sprite_pkg::*;

    logic                  scan_req;
    logic                  scan_gnt;
    logic [`OBJ_IDX_W-1:0] scan_idx;
    obj_word_t             scan_word;
    logic                  wr_en;
    logic [`ENTRY_W-1:0]   wr_entry;

    obj_ram_arbiter u_ram (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_data  ( cpu_data  ),
        .scan_req  ( scan_req  ),
        .scan_idx  ( scan_idx  ),
        .scan_gnt  ( scan_gnt  ),
        .scan_word ( scan_word )
    );

    obj_scanner u_scan (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .line_start ( line_start ),
        .line_v     ( line_v     ),
        .scan_gnt   ( scan_gnt   ),
        .scan_word  ( scan_word  ),
        .scan_req   ( scan_req   ),
        .scan_idx   ( scan_idx   ),
        .wr_en      ( wr_en      ),
        .wr_entry   ( wr_entry   ),
        .scan_done  ( scan_done  )
    );

    line_buffer u_lbuf (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .line_start ( line_start ),
        .wr_en      ( wr_en      ),
        .wr_entry   ( wr_entry   ),
        .rd_en      ( rd_en      ),
        .rd_slot    ( rd_slot    ),
        .rd_valid   ( rd_valid   ),
        .rd_entry   ( rd_entry   ),
        .slot_count ( slot_count ),
        .overflow   ( overflow   )
    );

endmodule

`default_nettype wire

// File: verilog/line_buffer.sv
/*
    ping-pong line buffer
    two 8-slot halves; one fills from the scanner while the other
    is read back by the renderer. line start swaps them
*/
`timescale 1ns/100ps
`default_nettype none

`include "sprite_defs.svh"

module line_buffer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     line_start,
    // scanner side
    input  wire                     wr_en,
    input  wire [`ENTRY_W-1:0]      wr_entry,
    // renderer side
    input  wire                     rd_en,
    input  wire [`SLOT_W-1:0]       rd_slot,
    output logic                    rd_valid,
    output logic [`ENTRY_W-1:0]     rd_entry,
    output logic [`SLOT_W:0]        slot_count,
    output logic                    overflow
);

    localparam logic [`SLOT_W:0] FULL = `LINE_SLOTS;

    logic [`ENTRY_W-1:0] mem [2][`LINE_SLOTS];   // entry storage, no reset
    logic [`SLOT_W:0]    count [2];              // fill level per half
    logic [1:0]          ovf;                    // per half
    logic                fill;                   // half being written
    logic                disp;                   // half on display
    logic                full;
    logic                wr_ok;

    assign disp  = ~fill;
    assign full  = (count[fill] == FULL);
    // line start wins over a late write from an aborted scan
    assign wr_ok = wr_en & ~line_start & ~full;

    assign slot_count = count[disp];
    assign overflow   = ovf[disp];

    always_ff @(posedge clk) begin
        if (reset) begin
            fill     <= 1'b0;
            count[0] <= '0;
            count[1] <= '0;
            ovf      <= 2'b00;
        end else if (line_start) begin
            fill        <= ~fill;       // old fill half goes on display
            count[disp] <= '0;          // old display half starts filling
            ovf[disp]   <= 1'b0;
        end else if (wr_en) begin
            if (full) begin
                ovf[fill] <= 1'b1;      // ninth object and on, entry dropped
            end else begin
                count[fill] <= count[fill] + 1'b1;
            end
        end
    end

    // slot picked from the fill counter
    always_ff @(posedge clk) begin
        if (wr_ok) mem[fill][count[fill][`SLOT_W-1:0]] <= wr_entry;
    end

    always_ff @(posedge clk) begin
        if (reset) rd_valid <= 1'b0;
        else       rd_valid <= rd_en;   // exactly one cycle later
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if ({1'b0, rd_slot} < count[disp])
                rd_entry <= mem[disp][rd_slot];
            else
                rd_entry <= '0;         // empty slot
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_scanner.sv
/*
    object scanner
    on every line start walks all objects, tests each one against
    the next line and sends in-zone objects to the line buffer
*/
`timescale 1ns/100ps
`default_nettype none

`include "sprite_defs.svh"

module obj_scanner (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      line_start,
    input  wire [7:0]                line_v,
    // object RAM port
    input  wire                      scan_gnt,
    input  sprite_pkg::obj_word_t    scan_word,
    output logic                     scan_req,
    output logic [`OBJ_IDX_W-1:0]    scan_idx,
    // line buffer port
    output logic                     wr_en,
    output logic [`ENTRY_W-1:0]      wr_entry,
    output logic                     scan_done
);

    import sprite_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;   // hold request until granted
    localparam logic [1:0] ST_WAIT = 2'd2;   // word arrives
    localparam logic [1:0] ST_DEC  = 2'd3;   // zone test, entry out
    localparam logic [`OBJ_IDX_W-1:0] LAST_IDX = `OBJ_IDX_W'(`OBJ_COUNT - 1);

    logic [1:0]              state;
    logic [7:0]              target;         // line being prepared
    obj_word_t               obj_q;          // latched object word
    logic [7:0]              diff;
    logic                    in_zone;
    logic [`ENTRY_BID_W-1:0] bank_id;
    logic [`ENTRY_PAL_W-1:0] pal;
    logic [`ENTRY_ROW_W-1:0] row;
    logic [`ENTRY_X_W-1:0]   xpos;

    // zone test, wraps modulo 256
    assign diff    = target - obj_q.f.y;
    assign in_zone = diff < 8'(`OBJ_H);

    assign bank_id = {obj_q.f.bank, obj_q.f.id};
    assign pal     = obj_q.f.pal;
    assign row     = diff[2:0] ^ {3{obj_q.f.vflip}};  // upside down
    assign xpos    = obj_q.f.x;

    assign scan_req = (state == ST_REQ);
    assign wr_en    = (state == ST_DEC) && in_zone;
    assign wr_entry = {bank_id, pal, obj_q.f.hflip, row, xpos};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            scan_idx  <= '0;
            target    <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (line_start) begin
                // restart, drops whatever scan was running
                state    <= ST_REQ;
                scan_idx <= '0;
                target   <= line_v + 8'd1;
            end else begin
                case (state)
                    ST_REQ:  if (scan_gnt) state <= ST_WAIT;
                    ST_WAIT: state <= ST_DEC;
                    ST_DEC: begin
                        if (scan_idx == LAST_IDX) begin
                            state     <= ST_IDLE;
                            scan_done <= 1'b1;   // one cycle after last decision
                        end else begin
                            state    <= ST_REQ;
                            scan_idx <= scan_idx + 1'b1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT) obj_q <= scan_word;  // word valid after grant
    end

endmodule

`default_nettype wire

// File: verilog/obj_ram_arbiter.sv
/*
    object RAM with arbiter
    16 words written a byte at a time by the CPU, read whole by
    the scanner. CPU writes always win; the scanner request is
    granted in free cycles and the word comes out a cycle later
*/
`timescale 1ns/100ps
`default_nettype none

`include "sprite_defs.svh"

module obj_ram_arbiter (
    input  wire                      clk,
    input  wire                      reset,
    // cpu side
    input  wire                      cpu_we,
    input  wire [5:0]                cpu_addr,    // {object, byte}
    input  wire [7:0]                cpu_data,
    // scanner side
    input  wire                      scan_req,
    input  wire [`OBJ_IDX_W-1:0]     scan_idx,
    output logic                     scan_gnt,
    output sprite_pkg::obj_word_t    scan_word
);

    import sprite_pkg::*;

    obj_word_t mem [`OBJ_COUNT];         // attribute RAM

    logic [`OBJ_IDX_W-1:0] wr_obj;
    logic [1:0]            wr_byte;

    assign wr_obj  = cpu_addr[5:2];
    assign wr_byte = cpu_addr[1:0];

    // cpu has priority over the scanner
    assign scan_gnt = scan_req & ~cpu_we;

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[wr_obj].b[wr_byte] <= cpu_data;  // byte lane write
        end
        if (scan_gnt) begin
            scan_word <= mem[scan_idx];          // valid next cycle
        end
    end

endmodule

`default_nettype wire

// File: verilog/sprite_pkg.sv
/*
    sprite object word
    one 32-bit object RAM word, seen as four bytes by the CPU
    and as attribute fields by the line scanner
*/
`default_nettype none

package sprite_pkg;

    // byte 0 y, byte 1 x, byte 2 {bank,id}, byte 3 {spare,vflip,hflip,pal}
    typedef union packed {
        logic [3:0][7:0] b;     // cpu view, b[0] is y
        struct packed {
            logic [2:0] spare;  // unused, kept for the cpu
            logic       vflip;  // row inversion
            logic       hflip;  // passed on to the renderer
            logic [2:0] pal;    // palette
            logic       bank;   // id msb / tile bank
            logic [6:0] id;     // tile code
            logic [7:0] x;      // horizontal position
            logic [7:0] y;      // top line of the object
        } f;                    // scanner view
    } obj_word_t;

endpackage

`default_nettype wire

// File: verilog/sprite_defs.svh
/*
    sprite line buffer sizes
    object RAM depth, line slot count and the layout of one
    line-buffer entry, MSB first: bank+id, palette, hflip, row, x
*/
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// object RAM
`define OBJ_COUNT   16      // objects in RAM
`define OBJ_IDX_W   4       // object index bits
`define OBJ_H       8       // lines per object

// line buffer
`define LINE_SLOTS  8       // entries per line
`define SLOT_W      3       // slot index bits

// entry fields
`define ENTRY_BID_W 8       // bank + id
`define ENTRY_PAL_W 3       // palette
`define ENTRY_ROW_W 3       // row inside the object
`define ENTRY_X_W   8       // horizontal position
`define ENTRY_W     23      // 8+3+1+3+8

`endif
